// File: rc4_macros.svh
`ifndef RC4_MACROS_SVH
`define RC4_MACROS_SVH

// Datapath widths
`define RC4_DATA_W      8
`define RC4_SBOX_AW     8
`define RC4_MSG_AW      5

// Message and key sizes
`define RC4_MSG_LEN     32
`define RC4_KEY_W       24
`define RC4_KEY_BYTES   3

// Accepted plaintext characters, lower case letters and space
`define RC4_CHAR_MIN    97
`define RC4_CHAR_MAX    122
`define RC4_CHAR_SPACE  32

`endif

// File: rc4_pkg.sv
`include "rc4_macros.svh"

package rc4_pkg;

    typedef logic [`RC4_DATA_W-1:0]  byte_t;
    typedef logic [`RC4_SBOX_AW-1:0] sbox_addr_t;
    typedef logic [`RC4_MSG_AW-1:0]  msg_addr_t;
    typedef logic [`RC4_KEY_W-1:0]   key_t;

    // One access on the S-box port
    typedef struct packed {
        logic       en;
        logic       we;     // 1 = write, 0 = read
        sbox_addr_t addr;
        byte_t      wdata;
    } sbox_req_t;

    typedef struct packed {
        logic       start;
        sbox_addr_t addr_i;
        sbox_addr_t addr_j;
    } swap_cmd_t;

    // si and sj are the values read before the exchange
    typedef struct packed {
        logic  done;
        byte_t si;
        byte_t sj;
    } swap_rsp_t;

    typedef struct packed {
        logic      valid;
        msg_addr_t addr;
        byte_t     data;
    } result_wr_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_INIT,
        PH_KEYSCHED,
        PH_DECRYPT
    } phase_t;

    typedef enum logic [2:0] {
        SW_IDLE,
        SW_RD_I,
        SW_RD_J,
        SW_CAP_J,
        SW_WR_I,
        SW_WR_J,
        SW_DONE
    } swap_state_t;

    typedef enum logic [2:0] {
        KS_IDLE,
        KS_READ,
        KS_ADD,
        KS_SWAP,
        KS_WAIT_SWAP,
        KS_DONE
    } ksa_state_t;

    typedef enum logic [3:0] {
        DC_IDLE,
        DC_READ_I,
        DC_ADD_J,
        DC_SWAP,
        DC_WAIT_SWAP,
        DC_READ_K,
        DC_WAIT_K,
        DC_WRITE,
        DC_DONE
    } dec_state_t;

endpackage

// File: sbox_mem.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module sbox_mem (
    input  logic              clk,
    input  rc4_pkg::sbox_req_t req,
    output rc4_pkg::byte_t    rdata
);

    rc4_pkg::byte_t mem [0:(1 << `RC4_SBOX_AW) - 1];

    // Single port, read data registered and held until the next read
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

// File: sbox_swap.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module sbox_swap (
    input  logic               clk,
    input  logic               reset,
    input  rc4_pkg::swap_cmd_t cmd,
    input  rc4_pkg::byte_t     rdata,
    output rc4_pkg::sbox_req_t req,
    output logic               busy,
    output rc4_pkg::swap_rsp_t rsp
);

    rc4_pkg::swap_state_t state;
    rc4_pkg::sbox_addr_t  addr_i;
    rc4_pkg::sbox_addr_t  addr_j;
    rc4_pkg::byte_t       si_reg;
    rc4_pkg::byte_t       sj_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rc4_pkg::SW_IDLE;
        end else begin
            case (state)
                rc4_pkg::SW_IDLE: begin
                    if (cmd.start) begin
                        state <= rc4_pkg::SW_RD_I;
                    end
                end
                rc4_pkg::SW_RD_I:  state <= rc4_pkg::SW_RD_J;
                rc4_pkg::SW_RD_J:  state <= rc4_pkg::SW_CAP_J;    // s[i] arrives here
                rc4_pkg::SW_CAP_J: state <= rc4_pkg::SW_WR_I;     // s[j] arrives here
                rc4_pkg::SW_WR_I:  state <= rc4_pkg::SW_WR_J;
                rc4_pkg::SW_WR_J:  state <= rc4_pkg::SW_DONE;
                default:           state <= rc4_pkg::SW_IDLE;
            endcase
        end
    end

    // Addresses and captured values
    always_ff @(posedge clk) begin
        if (state == rc4_pkg::SW_IDLE && cmd.start) begin
            addr_i <= cmd.addr_i;
            addr_j <= cmd.addr_j;
        end
        if (state == rc4_pkg::SW_RD_J) begin
            si_reg <= rdata;
        end
        if (state == rc4_pkg::SW_CAP_J) begin
            sj_reg <= rdata;
        end
    end

    always_comb begin
        req = '0;
        case (state)
            rc4_pkg::SW_RD_I: begin
                req.en   = 1'b1;
                req.addr = addr_i;
            end
            rc4_pkg::SW_RD_J: begin
                req.en   = 1'b1;
                req.addr = addr_j;
            end
            rc4_pkg::SW_WR_I: begin    // Old s[j] into slot i
                req.en    = 1'b1;
                req.we    = 1'b1;
                req.addr  = addr_i;
                req.wdata = sj_reg;
            end
            rc4_pkg::SW_WR_J: begin
                req.en    = 1'b1;
                req.we    = 1'b1;
                req.addr  = addr_j;
                req.wdata = si_reg;
            end
            default: req = '0;
        endcase
    end

    assign busy     = (state != rc4_pkg::SW_IDLE);
    assign rsp.done = (state == rc4_pkg::SW_DONE);
    assign rsp.si   = si_reg;
    assign rsp.sj   = sj_reg;

endmodule

// File: sbox_init.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module sbox_init (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output rc4_pkg::sbox_req_t req,
    output logic               finished
);

    rc4_pkg::sbox_addr_t cnt;
    logic                active;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt      <= '0;
            active   <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (active) begin
                cnt <= cnt + 1'b1;
                // Last address written, counter wraps back to zero
                if (cnt == {`RC4_SBOX_AW{1'b1}}) begin
                    active   <= 1'b0;
                    finished <= 1'b1;
                end
            end else if (start) begin
                cnt    <= '0;
                active <= 1'b1;
            end
        end
    end

    // Identity fill, s[x] = x
    assign req.en    = active;
    assign req.we    = active;
    assign req.addr  = cnt;
    assign req.wdata = cnt;

endmodule

// File: key_schedule.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module key_schedule (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  rc4_pkg::key_t      secret_key,
    input  rc4_pkg::byte_t     rdata,
    input  rc4_pkg::swap_rsp_t swap,
    output rc4_pkg::sbox_req_t req,
    output rc4_pkg::swap_cmd_t swap_cmd,
    output logic               finished
);

    rc4_pkg::ksa_state_t state;
    rc4_pkg::sbox_addr_t i;
    rc4_pkg::sbox_addr_t j;
    logic [1:0]          kidx;      // i mod 3
    rc4_pkg::byte_t      key_byte;

    // Byte 0 sits in the top bits of the key
    assign key_byte = secret_key[(`RC4_KEY_BYTES - 1 - kidx) * `RC4_DATA_W +: `RC4_DATA_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rc4_pkg::KS_IDLE;
            i     <= '0;
            j     <= '0;
            kidx  <= '0;
        end else begin
            case (state)
                rc4_pkg::KS_IDLE: begin
                    if (start) begin
                        i     <= '0;
                        j     <= '0;
                        kidx  <= '0;
                        state <= rc4_pkg::KS_READ;
                    end
                end
                rc4_pkg::KS_READ: state <= rc4_pkg::KS_ADD;
                rc4_pkg::KS_ADD: begin
                    j     <= j + rdata + key_byte;     // rdata holds s[i]
                    state <= rc4_pkg::KS_SWAP;
                end
                rc4_pkg::KS_SWAP: state <= rc4_pkg::KS_WAIT_SWAP;
                rc4_pkg::KS_WAIT_SWAP: begin
                    if (swap.done) begin
                        if (i == {`RC4_SBOX_AW{1'b1}}) begin
                            state <= rc4_pkg::KS_DONE;
                        end else begin
                            i     <= i + 1'b1;
                            kidx  <= (kidx == `RC4_KEY_BYTES - 1) ? 2'd0 : kidx + 2'd1;
                            state <= rc4_pkg::KS_READ;
                        end
                    end
                end
                default: state <= rc4_pkg::KS_IDLE;
            endcase
        end
    end

    assign req.en    = (state == rc4_pkg::KS_READ);
    assign req.we    = 1'b0;
    assign req.addr  = i;
    assign req.wdata = '0;

    assign swap_cmd.start  = (state == rc4_pkg::KS_SWAP);
    assign swap_cmd.addr_i = i;
    assign swap_cmd.addr_j = j;

    assign finished = (state == rc4_pkg::KS_DONE);

endmodule

// File: message_decrypt.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module message_decrypt (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  rc4_pkg::byte_t      rdata,
    input  rc4_pkg::swap_rsp_t  swap,
    input  rc4_pkg::byte_t      rom_data,
    output rc4_pkg::sbox_req_t  req,
    output rc4_pkg::swap_cmd_t  swap_cmd,
    output rc4_pkg::msg_addr_t  rom_addr,
    output rc4_pkg::result_wr_t result,
    output logic                data_invalid,
    output logic                finished
);

    rc4_pkg::dec_state_t state;
    rc4_pkg::sbox_addr_t i;
    rc4_pkg::sbox_addr_t j;
    rc4_pkg::msg_addr_t  k;
    rc4_pkg::byte_t      plain;
    logic                bad_char;

    // Only a to z and space are accepted
    assign bad_char = (plain > `RC4_CHAR_MAX) ||
                      ((plain < `RC4_CHAR_MIN) && (plain != `RC4_CHAR_SPACE));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= rc4_pkg::DC_IDLE;
            i            <= '0;
            j            <= '0;
            k            <= '0;
            data_invalid <= 1'b0;
        end else begin
            case (state)
                rc4_pkg::DC_IDLE: begin
                    if (start) begin
                        i            <= 8'd1;    // i starts at 0 and is bumped first
                        j            <= '0;
                        k            <= '0;
                        data_invalid <= 1'b0;
                        state        <= rc4_pkg::DC_READ_I;
                    end
                end
                rc4_pkg::DC_READ_I: state <= rc4_pkg::DC_ADD_J;
                rc4_pkg::DC_ADD_J: begin
                    j     <= j + rdata;
                    state <= rc4_pkg::DC_SWAP;
                end
                rc4_pkg::DC_SWAP: state <= rc4_pkg::DC_WAIT_SWAP;
                rc4_pkg::DC_WAIT_SWAP: begin
                    if (swap.done) begin
                        state <= rc4_pkg::DC_READ_K;
                    end
                end
                rc4_pkg::DC_READ_K: state <= rc4_pkg::DC_WAIT_K;
                rc4_pkg::DC_WAIT_K: state <= rc4_pkg::DC_WRITE;
                rc4_pkg::DC_WRITE: begin
                    data_invalid <= data_invalid | bad_char;
                    if (k == `RC4_MSG_LEN - 1) begin
                        state <= rc4_pkg::DC_DONE;
                    end else begin
                        k     <= k + 1'b1;
                        i     <= i + 1'b1;
                        state <= rc4_pkg::DC_READ_I;
                    end
                end
                default: state <= rc4_pkg::DC_IDLE;
            endcase
        end
    end

    // Keystream byte and ciphertext both valid in WAIT_K
    always_ff @(posedge clk) begin
        if (state == rc4_pkg::DC_WAIT_K) begin
            plain <= rom_data ^ rdata;
        end
    end

    // Old si + old sj equals new s[j] + new s[i]
    always_comb begin
        req = '0;
        if (state == rc4_pkg::DC_READ_I) begin
            req.en   = 1'b1;
            req.addr = i;
        end else if (state == rc4_pkg::DC_READ_K) begin
            req.en   = 1'b1;
            req.addr = swap.si + swap.sj;
        end
    end

    assign swap_cmd.start  = (state == rc4_pkg::DC_SWAP);
    assign swap_cmd.addr_i = i;
    assign swap_cmd.addr_j = j;

    assign rom_addr = k;    // Stable for many cycles before each use

    assign result.valid = (state == rc4_pkg::DC_WRITE);
    assign result.addr  = k;
    assign result.data  = plain;

    assign finished = (state == rc4_pkg::DC_DONE);

endmodule

// File: rc4_decrypt.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module rc4_decrypt (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  rc4_pkg::key_t       secret_key,
    input  rc4_pkg::byte_t      rom_data,
    output rc4_pkg::msg_addr_t  rom_addr,
    output rc4_pkg::result_wr_t result,
    output logic                data_invalid,
    output logic                done
);

    rc4_pkg::phase_t    phase;
    logic               init_start, ks_start, dec_start;
    logic               init_finished, ks_finished, dec_finished;

    rc4_pkg::sbox_req_t mem_req, init_req, ks_req, dec_req, swap_req;
    rc4_pkg::byte_t     sbox_rdata;
    rc4_pkg::swap_cmd_t swap_cmd, ks_cmd, dec_cmd;
    rc4_pkg::swap_rsp_t swap_rsp;
    logic               swap_busy;

    // Phase sequencer, one start pulse per controller
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= rc4_pkg::PH_IDLE;
            init_start <= 1'b0;
            ks_start   <= 1'b0;
            dec_start  <= 1'b0;
            done       <= 1'b0;
        end else begin
            init_start <= 1'b0;
            ks_start   <= 1'b0;
            dec_start  <= 1'b0;
            done       <= 1'b0;
            case (phase)
                rc4_pkg::PH_IDLE: begin
                    if (start) begin
                        phase      <= rc4_pkg::PH_INIT;
                        init_start <= 1'b1;
                    end
                end
                rc4_pkg::PH_INIT: begin
                    if (init_finished) begin
                        phase    <= rc4_pkg::PH_KEYSCHED;
                        ks_start <= 1'b1;
                    end
                end
                rc4_pkg::PH_KEYSCHED: begin
                    if (ks_finished) begin
                        phase     <= rc4_pkg::PH_DECRYPT;
                        dec_start <= 1'b1;
                    end
                end
                default: begin
                    if (dec_finished) begin
                        phase <= rc4_pkg::PH_IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // S-box port owner, the swap unit wins while busy
    always_comb begin
        if (swap_busy) begin
            mem_req = swap_req;
        end else begin
            case (phase)
                rc4_pkg::PH_INIT:     mem_req = init_req;
                rc4_pkg::PH_KEYSCHED: mem_req = ks_req;
                rc4_pkg::PH_DECRYPT:  mem_req = dec_req;
                default:              mem_req = '0;
            endcase
        end
    end

    assign swap_cmd = (phase == rc4_pkg::PH_DECRYPT) ? dec_cmd : ks_cmd;

    sbox_mem i_sbox_mem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (sbox_rdata)
    );

    sbox_swap i_sbox_swap (
        .clk   (clk),
        .reset (reset),
        .cmd   (swap_cmd),
        .rdata (sbox_rdata),
        .req   (swap_req),
        .busy  (swap_busy),
        .rsp   (swap_rsp)
    );

    sbox_init i_sbox_init (
        .clk      (clk),
        .reset    (reset),
        .start    (init_start),
        .req      (init_req),
        .finished (init_finished)
    );

    key_schedule i_key_schedule (
        .clk        (clk),
        .reset      (reset),
        .start      (ks_start),
        .secret_key (secret_key),
        .rdata      (sbox_rdata),
        .swap       (swap_rsp),
        .req        (ks_req),
        .swap_cmd   (ks_cmd),
        .finished   (ks_finished)
    );

    message_decrypt i_message_decrypt (
        .clk          (clk),
        .reset        (reset),
        .start        (dec_start),
        .rdata        (sbox_rdata),
        .swap         (swap_rsp),
        .rom_data     (rom_data),
        .req          (dec_req),
        .swap_cmd     (dec_cmd),
        .rom_addr     (rom_addr),
        .result       (result),
        .data_invalid (data_invalid),
        .finished     (dec_finished)
    );

endmodule

// File: tb_rc4_decrypt.sv
`timescale 1ns/10ps
`include "rc4_macros.svh"

module tb_rc4_decrypt;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_RUNS   = 10;
    localparam int RUN_CYCLES = 10000;
    localparam int IDLE_CHECK = 4000;    // Long enough for a stray second run to show

    logic                clk;
    logic                reset;
    logic                start;
    rc4_pkg::key_t       secret_key;
    rc4_pkg::byte_t      rom_data;
    rc4_pkg::msg_addr_t  rom_addr;
    rc4_pkg::result_wr_t result;
    logic                data_invalid;
    logic                done;

    rc4_pkg::byte_t plain_msg [0:`RC4_MSG_LEN-1];
    rc4_pkg::byte_t rom [0:`RC4_MSG_LEN-1];          // Ciphertext
    rc4_pkg::byte_t got_data [0:`RC4_MSG_LEN-1];
    int             write_count [0:`RC4_MSG_LEN-1];
    int             write_total;
    int             done_count;
    int             done_writes;     // Writes seen when done was high
    logic [31:0]    lcg_state;

    rc4_decrypt i_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .secret_key   (secret_key),
        .rom_data     (rom_data),
        .rom_addr     (rom_addr),
        .result       (result),
        .data_invalid (data_invalid),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Synchronous ROM with data one cycle after the address
    always @(posedge clk) begin
        rom_data <= #1 rom[rom_addr];
    end

    // Result monitor
    always @(negedge clk) begin
        if (result.valid === 1'b1) begin
            write_count[result.addr] = write_count[result.addr] + 1;
            got_data[result.addr]    = result.data;
            write_total              = write_total + 1;
        end
        if (done === 1'b1) begin
            done_count  = done_count + 1;
            done_writes = write_total;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic char_allowed(input rc4_pkg::byte_t b);
        return (b == `RC4_CHAR_SPACE) || ((b >= `RC4_CHAR_MIN) && (b <= `RC4_CHAR_MAX));
    endfunction

    function automatic logic expected_invalid();
        logic bad;
        bad = 1'b0;
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            if (!char_allowed(plain_msg[k])) begin
                bad = 1'b1;
            end
        end
        return bad;
    endfunction

    function automatic rc4_pkg::byte_t key_byte_of(input rc4_pkg::key_t key, input int idx);
        case (idx)
            0:       return key[23:16];
            1:       return key[15:8];
            default: return key[7:0];
        endcase
    endfunction

    function automatic int random_position();
        logic [31:0] r;
        r = next_random();
        return int'(r[31:27]);
    endfunction

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_with(input string what);
        $display("%s (time %0t)", what, $time);
        stop_on_failure();
    endtask

    task automatic check_byte(input string name, input rc4_pkg::byte_t got,
                              input rc4_pkg::byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // Random a to z and space plus one forbidden byte at bad_pos if set
    task automatic fill_message(input int bad_pos);
        logic [31:0]    r;
        int             pick;
        rc4_pkg::byte_t b;
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            r    = next_random();
            pick = int'(r[23:16]) % 27;
            plain_msg[k] = (pick == 26) ? 8'(`RC4_CHAR_SPACE) : 8'(`RC4_CHAR_MIN + pick);
        end
        if (bad_pos >= 0) begin
            do begin
                r = next_random();
                b = r[31:24];
            end while (char_allowed(b));
            plain_msg[bad_pos] = b;
        end
    endtask

    // Reference RC4 producing ciphertext as plaintext XOR keystream
    task automatic encrypt_message(input rc4_pkg::key_t key);
        rc4_pkg::byte_t      s [0:255];
        rc4_pkg::sbox_addr_t i;
        rc4_pkg::sbox_addr_t j;
        rc4_pkg::sbox_addr_t t;
        rc4_pkg::byte_t      tmp;
        for (int n = 0; n < 256; n++) begin
            s[n] = 8'(n);
        end
        j = '0;
        for (int n = 0; n < 256; n++) begin
            j    = j + s[n] + key_byte_of(key, n % 3);
            tmp  = s[n];
            s[n] = s[j];
            s[j] = tmp;
        end
        i = '0;
        j = '0;
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            i      = i + 8'd1;
            j      = j + s[i];
            tmp    = s[i];
            s[i]   = s[j];
            s[j]   = tmp;
            t      = s[i] + s[j];    // Wraps mod 256
            rom[k] = plain_msg[k] ^ s[t];
        end
    endtask

    task automatic clear_scoreboard();
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            write_count[k] = 0;
            got_data[k]    = '0;
        end
        write_total = 0;
        done_count  = 0;
        done_writes = 0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic start_run(input int bad_pos);
        logic [31:0]   r;
        rc4_pkg::key_t key;
        r   = next_random();
        key = r[31:8];
        fill_message(bad_pos);
        encrypt_message(key);
        clear_scoreboard();
        @(posedge clk);
        #1;
        secret_key = key;
        pulse_start();
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done_count == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_CYCLES) begin
                fail_with("done never pulsed, the run did not finish");
            end
        end
    endtask

    task automatic wait_for_writes(input int count);
        int cycles;
        cycles = 0;
        while (write_total < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_CYCLES) begin
                fail_with("result writes stopped before the expected count");
            end
        end
    endtask

    // Returns just after the rising edge that opens a write cycle
    task automatic wait_for_result_write();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > RUN_CYCLES) begin
                fail_with("no result write appeared");
            end
        end while (result.valid !== 1'b1);
    endtask

    task automatic check_run();
        @(negedge clk);
        @(negedge clk);
        if (done_count != 1) begin
            fail_with($sformatf("done was high for %0d cycles instead of one", done_count));
        end
        if (done_writes != `RC4_MSG_LEN) begin
            fail_with($sformatf("%0d result writes before done instead of %0d",
                                done_writes, `RC4_MSG_LEN));
        end
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            if (write_count[k] != 1) begin
                fail_with($sformatf("address %0d written %0d times", k, write_count[k]));
            end
            check_byte($sformatf("result.data[%0d]", k), got_data[k], plain_msg[k]);
        end
        check_bit("data_invalid", data_invalid, expected_invalid());
    endtask

    initial begin
        #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
        fail_with("watchdog expired, the test sequence did not complete in time");
    end

    initial begin
        lcg_state  = 32'h610b379e;
        reset      = 1'b1;
        start      = 1'b0;
        secret_key = '0;
        rom_data   = '0;
        for (int k = 0; k < `RC4_MSG_LEN; k++) begin
            rom[k] = '0;
        end
        clear_scoreboard();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Clean messages back to back with fresh keys
        for (int n = 0; n < 4; n++) begin
            start_run(-1);
            wait_for_done();
            check_run();
        end

        // A bad byte sets the flag and the next start clears it
        start_run(random_position());
        wait_for_done();
        check_run();
        start_run(-1);
        wait_for_done();
        check_run();
        start_run(random_position());
        wait_for_done();
        check_run();

        // Reset in the middle of a result write
        start_run(0);
        wait_for_writes(4);
        wait_for_result_write();
        check_bit("data_invalid", data_invalid, 1'b1);
        reset = 1'b1;
        #1;
        check_bit("result.valid", result.valid, 1'b0);
        check_bit("data_invalid", data_invalid, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (IDLE_CHECK) @(posedge clk);
        if ((done_count != 0) || (write_total != 4)) begin
            fail_with("the run cut off by reset carried on after reset");
        end
        start_run(-1);
        wait_for_done();
        check_run();

        // Extra starts in init, key schedule and decryption
        start_run(-1);
        repeat (100) @(posedge clk);
        pulse_start();
        repeat (1000) @(posedge clk);
        pulse_start();
        wait_for_writes(1);
        pulse_start();
        wait_for_done();
        check_run();
        repeat (IDLE_CHECK) @(posedge clk);
        if ((done_count != 1) || (write_total != `RC4_MSG_LEN)) begin
            fail_with("a start pulse during a busy run launched another run");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
rc4_pkg.sv
sbox_mem.sv
sbox_swap.sv
sbox_init.sv
key_schedule.sv
message_decrypt.sv
rc4_decrypt.sv
tb_rc4_decrypt.sv

// File: Bender.yml
package:
  name: rc4_decrypt

sources:
  - include_dirs:
      - .
    files:
      - rc4_pkg.sv
      - sbox_mem.sv
      - sbox_swap.sv
      - sbox_init.sv
      - key_schedule.sv
      - message_decrypt.sv
      - rc4_decrypt.sv
      - target: test
        files:
          - tb_rc4_decrypt.sv
